//--- logic/ssc_pkg.sv
// Shared sizes, data types and FSM states of the snack shopping calculator, referenced by scope
`default_nettype none

package ssc_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int NUM_SNACKS  = 8;
    localparam int DIGIT_W     = 4;
    localparam int CARD_DIGITS = 16;

    // A 4-bit count times a 4-bit price
    localparam int TOTAL_W     = 8;
    localparam int MONEY_W     = 9;
    localparam int IDX_W       = 3;

    // Card checksum must land on a multiple of this
    localparam int CHECK_MOD   = 10;

    // ====================
    // Types
    // ====================

    typedef logic [TOTAL_W-1:0] total_t;
    typedef logic [MONEY_W-1:0] money_t;
    typedef logic [IDX_W-1:0]   idx_t;

    // Element 0 is the most expensive once sorted
    typedef total_t [NUM_SNACKS-1:0] total_list_t;

    typedef enum logic [1:0] {
        IDLE,
        BUY,
        DONE
    } fsm_state_t;

endpackage

`default_nettype wire

//--- logic/purchase_if.sv
// Purchase handshake between the FSM, the item counter and the change datapath
`timescale 1ns/1ps
`default_nettype none

interface purchase_if;

    // FSM strobes that are never high together
    logic load;
    logic step;

    // Item position
    ssc_pkg::idx_t idx;
    logic          last;

    // Money left covers the total at idx
    logic affordable;

    modport ctrl (
        output load,
        output step,
        input  last,
        input  affordable
    );

    modport cnt (
        input  load,
        input  step,
        output idx,
        output last
    );

    modport data (
        input  load,
        input  step,
        input  idx,
        output affordable
    );

endinterface

`default_nettype wire

//--- logic/luhn_checker.sv
// Combinational card checksum; card_pass is high when the digit sum is a multiple of ten
`timescale 1ns/1ps
`default_nettype none

module luhn_checker (
    input  wire [ssc_pkg::CARD_DIGITS*ssc_pkg::DIGIT_W-1:0] card_num,
    output logic                                             card_pass
);

    // Sum of the decimal digits of twice the nibble, so 14 gives 10 and 15 gives 3
    function automatic int unsigned doubled_digit_sum(logic [ssc_pkg::DIGIT_W-1:0] digit);
        int unsigned dbl;
        dbl = 2 * digit;
        return (dbl / 10) + (dbl % 10);
    endfunction

    always_comb
    begin : checksum
        int unsigned                 sum;
        logic [ssc_pkg::DIGIT_W-1:0] digit;
        sum = 0;
        for (int i = 0; i < ssc_pkg::CARD_DIGITS; i++)
        begin
            digit = card_num[i*ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W];
            // Odd nibbles counted from the LSB end get doubled
            if (i % 2 == 1)
            begin
                sum += doubled_digit_sum(digit);
            end
            else
            begin
                sum += digit;
            end
        end
        card_pass = (sum % ssc_pkg::CHECK_MOD) == 0;
    end

endmodule

`default_nettype wire

//--- logic/price_sorter.sv
// Combinational snack totals (count times price) sorted largest first by a merge network
`timescale 1ns/1ps
`default_nettype none

module price_sorter (
    input  wire [ssc_pkg::NUM_SNACKS*ssc_pkg::DIGIT_W-1:0] snack_num,
    input  wire [ssc_pkg::NUM_SNACKS*ssc_pkg::DIGIT_W-1:0] price,
    output ssc_pkg::total_list_t                           sorted_totals
);

    ssc_pkg::total_list_t products;
    ssc_pkg::total_list_t halves;
    ssc_pkg::total_list_t merge_1;
    ssc_pkg::total_list_t merge_2;

    // Compare-exchange that leaves the larger value at index hi
    function automatic ssc_pkg::total_list_t cmp_swap(ssc_pkg::total_list_t list,
                                                      int hi, int lo);
        ssc_pkg::total_t tmp;
        if (list[hi] < list[lo])
        begin
            tmp      = list[hi];
            list[hi] = list[lo];
            list[lo] = tmp;
        end
        return list;
    endfunction

    // Five-comparator sort of list[base] .. list[base+3]
    function automatic ssc_pkg::total_list_t sort_four(ssc_pkg::total_list_t list, int base);
        list = cmp_swap(list, base,     base + 1);
        list = cmp_swap(list, base + 2, base + 3);
        list = cmp_swap(list, base,     base + 2);
        list = cmp_swap(list, base + 1, base + 3);
        list = cmp_swap(list, base + 1, base + 2);
        return list;
    endfunction

    // ====================
    // Totals
    // ====================

    always_comb
    begin
        for (int i = 0; i < ssc_pkg::NUM_SNACKS; i++)
        begin
            products[i] = ssc_pkg::total_t'(snack_num[i*ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W])
                        * ssc_pkg::total_t'(price[i*ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W]);
        end
    end

    // Both halves of four sorted on their own
    assign halves = sort_four(sort_four(products, 0), ssc_pkg::NUM_SNACKS / 2);

    // ====================
    // Merge network
    // ====================

    // Layer 1 pairs each slot with its partner in the other half
    always_comb
    begin
        merge_1 = halves;
        for (int i = 0; i < ssc_pkg::NUM_SNACKS / 2; i++)
        begin
            merge_1 = cmp_swap(merge_1, i, i + ssc_pkg::NUM_SNACKS / 2);
        end
    end

    always_comb
    begin
        merge_2 = cmp_swap(merge_1, 2, 4);
        merge_2 = cmp_swap(merge_2, 3, 5);
    end

    // Ends 0 and 7 are settled already
    always_comb
    begin
        sorted_totals = cmp_swap(merge_2, 1, 2);
        sorted_totals = cmp_swap(sorted_totals, 3, 4);
        sorted_totals = cmp_swap(sorted_totals, 5, 6);
    end

endmodule

`default_nettype wire

//--- logic/purchase_fsm.sv
// Control FSM that loads a request, steps the greedy purchase and flags the result for one cycle
`timescale 1ns/1ps
`default_nettype none

module purchase_fsm (
    input  wire       clk,
    input  wire       rst,
    input  wire       in_valid,
    input  wire       card_pass,
    purchase_if.ctrl  bus,
    output logic      out_valid,
    output logic      card_ok
);

    ssc_pkg::fsm_state_t state;
    ssc_pkg::fsm_state_t state_next;

    // Requests outside IDLE are dropped
    assign bus.load  = (state == ssc_pkg::IDLE) && in_valid;
    assign bus.step  = (state == ssc_pkg::BUY) && bus.affordable;
    assign out_valid = (state == ssc_pkg::DONE);

    always_comb
    begin
        state_next = state;
        case (state)
            ssc_pkg::IDLE:
            begin
                if (in_valid)
                begin
                    // Rejected card skips the purchase
                    state_next = card_pass ? ssc_pkg::BUY : ssc_pkg::DONE;
                end
            end
            ssc_pkg::BUY:
            begin
                // Stop at the first unaffordable item or after the last buy
                if (!bus.affordable || bus.last)
                begin
                    state_next = ssc_pkg::DONE;
                end
            end
            ssc_pkg::DONE:
            begin
                state_next = ssc_pkg::IDLE;
            end
            default:
            begin
                state_next = ssc_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ssc_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Held until the next request is loaded
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            card_ok <= 1'b0;
        end
        else if (bus.load)
        begin
            card_ok <= card_pass;
        end
    end

endmodule

`default_nettype wire

//--- logic/item_counter.sv
// Index of the next sorted snack to buy, cleared on load and advanced on each step
`timescale 1ns/1ps
`default_nettype none

module item_counter (
    input  wire      clk,
    input  wire      rst,
    purchase_if.cnt  bus
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bus.idx <= '0;
        end
        else if (bus.load)
        begin
            bus.idx <= '0;
        end
        else if (bus.step)
        begin
            // The wrap after the last item is never read
            bus.idx <= bus.idx + 1'b1;
        end
    end

    assign bus.last = (bus.idx == ssc_pkg::idx_t'(ssc_pkg::NUM_SNACKS - 1));

endmodule

`default_nettype wire

//--- logic/change_datapath.sv
// Money-left register and sorted totals; tests and subtracts one total per purchase step
`timescale 1ns/1ps
`default_nettype none

module change_datapath (
    input  wire                         clk,
    input  wire                         rst,
    input  wire ssc_pkg::money_t        input_money,
    input  wire ssc_pkg::total_list_t   sorted_totals,
    purchase_if.data                    bus,
    output ssc_pkg::money_t             out_change
);

    ssc_pkg::money_t      money_left;
    ssc_pkg::total_list_t totals;
    ssc_pkg::money_t      cur_total;

    // Total of the item under the counter widened to money width
    assign cur_total = ssc_pkg::money_t'(totals[bus.idx]);

    assign bus.affordable = (cur_total <= money_left);

    assign out_change = money_left;

    // ====================
    // Money left
    // ====================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            money_left <= '0;
        end
        else if (bus.load)
        begin
            money_left <= input_money;
        end
        else if (bus.step)
        begin
            money_left <= money_left - cur_total;
        end
    end

    // Sorted list frozen for the whole purchase
    always_ff @(posedge clk)
    begin
        if (bus.load)
        begin
            totals <= sorted_totals;
        end
    end

endmodule

`default_nettype wire

//--- logic/ssc_top.sv
// Top level of the clocked snack shopping calculator; one request per in_valid pulse
`timescale 1ns/1ps
`default_nettype none

module ssc_top (
    input  wire                                                 clk,
    input  wire                                                 rst,
    input  wire                                                 in_valid,
    input  wire [ssc_pkg::CARD_DIGITS*ssc_pkg::DIGIT_W-1:0]     card_num,
    input  wire ssc_pkg::money_t                                input_money,
    input  wire [ssc_pkg::NUM_SNACKS*ssc_pkg::DIGIT_W-1:0]      snack_num,
    input  wire [ssc_pkg::NUM_SNACKS*ssc_pkg::DIGIT_W-1:0]      price,
    output wire                                                 out_valid,
    output wire ssc_pkg::money_t                                out_change,
    output wire                                                 card_ok
);

    wire                       card_pass;
    wire ssc_pkg::total_list_t sorted_totals;

    purchase_if purchase_bus ();

    // ====================
    // Request decode
    // ====================

    luhn_checker i_luhn_checker (
        .card_num  (card_num),
        .card_pass (card_pass)
    );

    price_sorter i_price_sorter (
        .snack_num     (snack_num),
        .price         (price),
        .sorted_totals (sorted_totals)
    );

    // ====================
    // Purchase sequence
    // ====================

    purchase_fsm i_purchase_fsm (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .card_pass (card_pass),
        .bus       (purchase_bus),
        .out_valid (out_valid),
        .card_ok   (card_ok)
    );

    item_counter i_item_counter (
        .clk (clk),
        .rst (rst),
        .bus (purchase_bus)
    );

    change_datapath i_change_datapath (
        .clk           (clk),
        .rst           (rst),
        .input_money   (input_money),
        .sorted_totals (sorted_totals),
        .bus           (purchase_bus),
        .out_change    (out_change)
    );

endmodule

`default_nettype wire

//--- testbench/ssc_props.sv
// Concurrent timing checks on the top-level strobes that bind attaches to every ssc_top instance
`timescale 1ns/1ps
`default_nettype none

module ssc_props (
    input wire                      clk,
    input wire                      rst,
    input wire                      in_valid,
    input wire                      card_pass,
    input wire                      out_valid,
    input wire ssc_pkg::fsm_state_t state
);

    // Result strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (rst) out_valid |=> !out_valid)
        else $error("out_valid high on two consecutive cycles");

    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high while reset was asserted");

    // Rejected card goes straight to the result
    assert property (@(posedge clk) disable iff (rst)
                     (state == ssc_pkg::IDLE && in_valid && !card_pass) |=> out_valid)
        else $error("rejected card did not give out_valid on the next cycle");

endmodule

bind ssc_top ssc_props i_ssc_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .card_pass (card_pass),
    .out_valid (out_valid),
    .state     (i_purchase_fsm.state)
);

`default_nettype wire

//--- testbench/ssc_tb.sv
// Random and directed testbench for ssc_top; a model predicts card check, change and latency
`timescale 1ns/1ps
`default_nettype none

module ssc_tb;

    localparam int NUM_RANDOM = 60;
    localparam int TIMEOUT    = 20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [63:0] card_num;
    logic [8:0]  input_money;
    logic [31:0] snack_num;
    logic [31:0] price;
    wire         out_valid;
    wire  [8:0]  out_change;
    wire         card_ok;

    logic [31:0] lcg_state;
    int          mismatch_count;
    int          failure_count;

    ssc_top i_ssc_top (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .out_valid   (out_valid),
        .out_change  (out_change),
        .card_ok     (card_ok)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ====================
    // Model
    // ====================

    // Odd nibbles count as the digit sum of their double, even nibbles as themselves
    function automatic int card_digit_sum(logic [63:0] card);
        int total;
        int d;
        total = 0;
        for (int i = 0; i < 16; i++)
        begin
            d = int'(card[i*4 +: 4]);
            if (i % 2 == 1)
            begin
                d = 2 * d;
                d = d / 10 + d % 10;
            end
            total += d;
        end
        return total;
    endfunction

    // Nibble 0 is rewritten so the digit sum becomes a multiple of ten
    function automatic logic [63:0] make_valid(logic [63:0] card);
        int s;
        card[3:0] = 4'd0;
        s = card_digit_sum(card);
        card[3:0] = 4'((10 - s % 10) % 10);
        return card;
    endfunction

    task automatic predict(input logic [63:0] card, input logic [8:0] money,
                           input logic [31:0] counts, input logic [31:0] prices,
                           output logic ok, output logic [8:0] change, output int latency);
        int totals [8];
        int tmp;
        int left;
        int bought;
        for (int i = 0; i < 8; i++)
        begin
            totals[i] = int'(counts[i*4 +: 4]) * int'(prices[i*4 +: 4]);
        end
        // Bubble sort into descending order
        for (int i = 0; i < 7; i++)
        begin
            for (int j = 0; j < 7 - i; j++)
            begin
                if (totals[j] < totals[j+1])
                begin
                    tmp         = totals[j];
                    totals[j]   = totals[j+1];
                    totals[j+1] = tmp;
                end
            end
        end
        ok     = (card_digit_sum(card) % 10) == 0;
        left   = int'(money);
        bought = 0;
        // Greedy buy that stops at the first unaffordable total
        while (ok && bought < 8 && totals[bought] <= left)
        begin
            left -= totals[bought];
            bought++;
        end
        change  = 9'(left);
        latency = !ok ? 1 : (bought == 8 ? 9 : bought + 2);
    endtask

    // ====================
    // Request driver
    // ====================

    task automatic run_request(input string name, input logic [63:0] card,
                               input logic [8:0] money, input logic [31:0] counts,
                               input logic [31:0] prices, input bit busy_pulse);
        logic       exp_ok;
        logic [8:0] exp_change;
        int         exp_latency;
        int         cycles;
        predict(card, money, counts, prices, exp_ok, exp_change, exp_latency);
        card_num    = card;
        input_money = money;
        snack_num   = counts;
        price       = prices;
        in_valid    = 1'b1;
        cycles      = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
            in_valid = 1'b0;
            if (busy_pulse && cycles == 2 && !out_valid)
            begin
                // Second request while the first one is still buying
                in_valid    = 1'b1;
                input_money = ~money;
                snack_num   = ~counts;
            end
        end
        while (!out_valid && cycles < TIMEOUT);
        assert (out_valid)
        else
        begin
            failure_count++;
            $display("timeout: %s never raised out_valid within %0d cycles", name, TIMEOUT);
        end
        if (out_valid)
        begin
            assert (card_ok == exp_ok)
            else
            begin
                mismatch_count++;
                $display("mismatch %s card_ok expected %0b actual %0b", name, exp_ok, card_ok);
            end
            assert (out_change == exp_change)
            else
            begin
                mismatch_count++;
                $display("mismatch %s change expected %0d actual %0d",
                         name, exp_change, out_change);
            end
            assert (cycles == exp_latency)
            else
            begin
                mismatch_count++;
                $display("mismatch %s latency expected %0d actual %0d",
                         name, exp_latency, cycles);
            end
        end
        // Result holds and no second strobe follows
        repeat (busy_pulse ? 12 : 2)
        begin
            @(posedge clk);
            #1;
            assert (!out_valid && out_change == exp_change)
            else
            begin
                failure_count++;
                $display("%s: extra out_valid or changed result after the strobe", name);
            end
        end
    endtask

    initial
    begin
        logic [63:0] card;
        logic [31:0] r;
        lcg_state      = 32'h6b01;
        mismatch_count = 0;
        failure_count  = 0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        card_num       = '0;
        input_money    = '0;
        snack_num      = '0;
        price          = '0;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            assert (!out_valid)
            else
            begin
                failure_count++;
                $display("out_valid went high during reset");
            end
        end
        rst = 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            #1;
            assert (!out_valid)
            else
            begin
                failure_count++;
                $display("out_valid went high before any request");
            end
        end

        // Corrupted nibble 0 breaks the checksum
        card      = make_valid({lcg_next(), lcg_next()});
        card[3:0] = 4'((card[3:0] + 5'd1) % 10);
        run_request("reject", card, 9'(lcg_next()), lcg_next(), lcg_next(), 1'b0);

        card = make_valid({lcg_next(), lcg_next()});
        run_request("buy_all", card, 9'd511, lcg_next() & 32'h33333333,
                    lcg_next() & 32'h33333333, 1'b0);
        run_request("busy", card, 9'd400, lcg_next() & 32'h33333333,
                    lcg_next() & 32'h33333333, 1'b1);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            card = {lcg_next(), lcg_next()};
            r    = lcg_next();
            if (r[16])
            begin
                card = make_valid(card);
            end
            r = lcg_next();
            run_request($sformatf("random_%0d", n), card, r[15:7], lcg_next(), lcg_next(), 1'b0);
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
logic/ssc_pkg.sv
logic/purchase_if.sv
logic/luhn_checker.sv
logic/price_sorter.sv
logic/purchase_fsm.sv
logic/item_counter.sv
logic/change_datapath.sv
logic/ssc_top.sv
testbench/ssc_props.sv
testbench/ssc_tb.sv

//--- Bender.yml
package:
  name: ssc

sources:
  - logic/ssc_pkg.sv
  - logic/purchase_if.sv
  - logic/luhn_checker.sv
  - logic/price_sorter.sv
  - logic/purchase_fsm.sv
  - logic/item_counter.sv
  - logic/change_datapath.sv
  - logic/ssc_top.sv
  - target: test
    files:
      - testbench/ssc_props.sv
      - testbench/ssc_tb.sv
